// File: logic/accel_geom_pkg.sv
package accel_geom_pkg;

    ////////////////////////////////////////////////////////////////////
    // loop geometry
    ////////////////////////////////////////////////////////////////////
    // rows per job, one dot product each
    localparam int ROWS = 8;
    // columns per row
    localparam int COLS = 128;

    // address and index widths
    localparam int SRC_AW = 10;
    localparam int MAT_AW = 7;
    localparam int ROW_W  = 3;

    // source buffer word address, row*128 + col
    typedef logic [SRC_AW-1:0] src_addr_t;
    // matrix word address, col only
    typedef logic [MAT_AW-1:0] mat_addr_t;
    // row index
    typedef logic [ROW_W-1:0]  row_idx_t;

    // result stream flow control
    typedef logic [2:0] credit_cnt_t;
    // credits held by the sender after reset
    localparam credit_cnt_t RESULT_CREDITS = 3'd4;

endpackage

// File: logic/accel_data_pkg.sv
package accel_data_pkg;

    // row index travels with each result
    import accel_geom_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // operand and accumulator types
    ////////////////////////////////////////////////////////////////////
    // 16-bit signed operand, both source and matrix
    typedef logic signed [15:0] operand_t;
    // 40-bit signed accumulator, also the result value
    typedef logic signed [39:0] acc_t;

    ////////////////////////////////////////////////////////////////////
    // host load request
    ////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        // 1 = matrix store, 0 = source buffer
        logic      to_matrix;
        // matrix uses only the low 7 bits
        src_addr_t addr;
        operand_t  data;
    } load_req_t;

    // one result beat on the output stream
    typedef struct packed {
        row_idx_t row;
        acc_t     value;
    } result_beat_t;

endpackage

// File: logic/agu_next.sv
`timescale 1ns/1ps
`default_nettype none

module agu_next #(
    parameter int W = 7
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         en,
    input  logic [W-1:0] ini,
    input  logic [W-1:0] fin,
    output logic [W-1:0] data,
    output logic         next,
    output logic         last
);

    logic [W-1:0] cnt;
    logic         run;
    logic         step;

    // start shows ini in the same cycle
    assign data = start ? ini : cnt;
    // step only while a run is live
    assign step = en & (start | run);
    assign last = step & (data == fin);
    assign next = step & (data != fin);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            run <= 1'b0;
        end else begin
            if (next) begin
                cnt <= data + 1'b1;
            end else if (start) begin
                cnt <= ini;
            end
            // final step ends the run
            if (last) begin
                run <= 1'b0;
            end else if (start) begin
                run <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl
    import accel_geom_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      s_init,
    input  logic      out_busy,
    input  logic      out_fin,
    output logic      s_fin,
    output logic      k_init,
    output logic      k_fin,
    output logic      exec,
    output src_addr_t exec_src_addr,
    output mat_addr_t exec_mat_addr
);

    row_idx_t  i;
    mat_addr_t j;
    logic      last_i, last_j;
    logic      next_i, next_j;
    logic      s_init_d;
    logic      row_more, row_req;
    logic      k_req, k_hold;
    logic      col_start;
    logic      fin_win;

    //////////////////////////////////////////////////////////////////////
    // row kick
    //////////////////////////////////////////////////////////////////////
    // first row one cycle after s_init, later rows one after k_fin
    assign k_req  = s_init_d | row_req | k_hold;
    // output stage full, hold the kick
    assign k_init = k_req & ~out_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_init_d  <= 1'b0;
            row_more  <= 1'b0;
            row_req   <= 1'b0;
            k_hold    <= 1'b0;
            col_start <= 1'b0;
            exec      <= 1'b0;
            k_fin     <= 1'b0;
            fin_win   <= 1'b0;
            s_fin     <= 1'b0;
        end else begin
            s_init_d  <= s_init;
            // next_i lines up with k_fin, row_req one later
            row_more  <= next_i;
            row_req   <= row_more;
            k_hold    <= k_req & out_busy;
            // column run starts after k_init
            col_start <= k_init;
            // high from k_init+1 through the last column
            exec      <= k_init | next_j;
            k_fin     <= last_j;
            // open on last row, close on its out_fin
            if (last_i) begin
                fin_win <= 1'b1;
            end else if (out_fin) begin
                fin_win <= 1'b0;
            end
            s_fin     <= fin_win & out_fin;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // loops
    //////////////////////////////////////////////////////////////////////
    // row loop, steps on the last column
    agu_next #(.W(ROW_W)) l_i (
        .clk(clk), .rst(rst), .start(s_init), .en(last_j),
        .ini('0), .fin(row_idx_t'(ROWS - 1)),
        .data(i), .next(next_i), .last(last_i)
    );

    // column loop, one step per exec cycle
    agu_next #(.W(MAT_AW)) l_j (
        .clk(clk), .rst(rst), .start(col_start), .en(exec),
        .ini('0), .fin(mat_addr_t'(COLS - 1)),
        .data(j), .next(next_j), .last(last_j)
    );

    // i*128 + j
    assign exec_src_addr = {i, j};
    assign exec_mat_addr = j;

endmodule

`default_nettype wire

// File: logic/operand_store.sv
`timescale 1ns/1ps
`default_nettype none

module operand_store
    import accel_geom_pkg::*;
    import accel_data_pkg::*;
(
    input  logic      clk,
    input  load_req_t load,
    input  src_addr_t src_raddr,
    input  mat_addr_t mat_raddr,
    output operand_t  src_data,
    output operand_t  mat_data
);

    // 1024 source words, 8 rows of 128
    operand_t src_mem [2**SRC_AW];
    // 128 matrix words
    operand_t mat_mem [2**MAT_AW];

    //////////////////////////////////////////////////////////////////////
    // host write port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (load.valid && !load.to_matrix) begin
            src_mem[load.addr] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        // low bits only for the matrix
        if (load.valid && load.to_matrix) begin
            mat_mem[load.addr[MAT_AW-1:0]] <= load.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////
    // data one cycle after address
    always_ff @(posedge clk) begin
        src_data <= src_mem[src_raddr];
        mat_data <= mat_mem[mat_raddr];
    end

endmodule

`default_nettype wire

// File: logic/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit
    import accel_geom_pkg::*;
    import accel_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         k_init,
    input  logic         exec,
    input  logic         k_fin,
    input  operand_t     src_data,
    input  operand_t     mat_data,
    output logic         result_valid,
    output result_beat_t result
);

    logic               exec_d;
    logic signed [31:0] prod;
    acc_t               acc;
    acc_t               acc_sum;
    row_idx_t           row_cnt;

    // full-width signed product
    assign prod    = src_data * mat_data;
    // last product folds in during k_fin
    assign acc_sum = exec_d ? acc + acc_t'(prod) : acc;

    // accumulator, cleared per row
    always_ff @(posedge clk) begin
        if (k_init) begin
            acc <= '0;
        end else if (exec_d) begin
            acc <= acc_sum;
        end
        if (k_fin) begin
            result.row   <= row_cnt;
            result.value <= acc_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_d       <= 1'b0;
            result_valid <= 1'b0;
            row_cnt      <= '0;
        end else begin
            // align with synchronous read data
            exec_d       <= exec;
            result_valid <= k_fin;
            // wraps after the 8th row
            if (k_fin) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/result_sender.sv
`timescale 1ns/1ps
`default_nettype none

module result_sender
    import accel_geom_pkg::*;
    import accel_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         result_valid,
    input  result_beat_t result,
    input  logic         res_credit,
    output logic         res_valid,
    output result_beat_t res_beat,
    output logic         out_busy,
    output logic         out_fin
);

    logic        full;
    credit_cnt_t credits;
    logic        send;

    //////////////////////////////////////////////////////////////////////
    // send decision
    //////////////////////////////////////////////////////////////////////
    assign send      = full & (credits != '0);
    assign res_valid = send;
    // beat leaves this cycle
    assign out_fin   = send;
    // no room for another row
    assign out_busy  = full | (credits == '0);

    // holding register, one beat
    always_ff @(posedge clk) begin
        if (result_valid) begin
            res_beat <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (result_valid) begin
            full <= 1'b1;
        end else if (send) begin
            full <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // credit counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= RESULT_CREDITS;
        end else begin
            case ({send, res_credit})
                2'b10: credits <= credits - 1'b1;
                // capped at the initial count
                2'b01: begin
                    if (credits != RESULT_CREDITS) begin
                        credits <= credits + 1'b1;
                    end
                end
                // send and return cancel out
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/mv_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module mv_engine_top
    import accel_geom_pkg::*;
    import accel_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  load_req_t    load,
    input  logic         s_init,
    input  logic         res_credit,
    output logic         s_fin,
    output logic         res_valid,
    output result_beat_t res_beat
);

    src_addr_t    exec_src_addr;
    mat_addr_t    exec_mat_addr;
    operand_t     src_data, mat_data;
    logic         k_init, k_fin, exec;
    logic         out_busy, out_fin;
    logic         result_valid;
    result_beat_t result;

    // operand memories
    operand_store u_store (
        .clk(clk), .load(load),
        .src_raddr(exec_src_addr), .mat_raddr(exec_mat_addr),
        .src_data(src_data), .mat_data(mat_data)
    );

    // row and column sequencing
    exe_ctrl u_ctrl (
        .clk(clk), .rst(rst), .s_init(s_init),
        .out_busy(out_busy), .out_fin(out_fin),
        .s_fin(s_fin), .k_init(k_init), .k_fin(k_fin), .exec(exec),
        .exec_src_addr(exec_src_addr), .exec_mat_addr(exec_mat_addr)
    );

    // dot product per row
    mac_unit u_mac (
        .clk(clk), .rst(rst), .k_init(k_init), .exec(exec), .k_fin(k_fin),
        .src_data(src_data), .mat_data(mat_data),
        .result_valid(result_valid), .result(result)
    );

    // credit-based output stream
    result_sender u_send (
        .clk(clk), .rst(rst), .result_valid(result_valid), .result(result),
        .res_credit(res_credit), .res_valid(res_valid), .res_beat(res_beat),
        .out_busy(out_busy), .out_fin(out_fin)
    );

endmodule

`default_nettype wire

// File: testbench/mv_engine_props.sv
`timescale 1ns/1ps

module mv_engine_props
    import accel_geom_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        exec,
    input logic        k_fin,
    input logic        s_fin,
    input logic        res_valid,
    input logic        res_credit,
    input credit_cnt_t credits
);

    // one counter per property, summed for the testbench
    int unsigned n_range = 0;
    int unsigned n_send = 0;
    int unsigned n_len = 0;
    int unsigned n_kfin = 0;
    int unsigned n_sfin = 0;
    int unsigned fail_cnt;
    int unsigned exec_len;
    // credits granted on the stream, beats taken off
    int          credits_seen;

    assign fail_cnt = n_range + n_send + n_len + n_kfin + n_sfin;

    // length of the current exec run
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_len <= 0;
        end else if (exec) begin
            exec_len <= exec_len + 1;
        end else begin
            exec_len <= 0;
        end
    end

    // consumer side view of the credit pool
    always_ff @(posedge clk) begin
        if (rst) begin
            credits_seen <= RESULT_CREDITS;
        end else if (res_valid && !res_credit) begin
            credits_seen <= credits_seen - 1;
        end else if (!res_valid && res_credit) begin
            credits_seen <= credits_seen + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stream credits
    //////////////////////////////////////////////////////////////////////
    // a wrap below zero also lands above the limit
    credit_range: assert property (@(posedge clk) disable iff (rst)
        credits <= RESULT_CREDITS)
        else begin
            $error("credit count %h outside 0 to 4", credits);
            n_range++;
        end

    // a beat needs a credit granted on the stream
    send_credit: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> credits_seen > 0)
        else begin
            $error("result beat sent with no credit left");
            n_send++;
        end

    //////////////////////////////////////////////////////////////////////
    // row framing
    //////////////////////////////////////////////////////////////////////
    // one exec cycle per column
    exec_length: assert property (@(posedge clk) disable iff (rst)
        $fell(exec) |-> exec_len == COLS)
        else begin
            $error("exec ran for %0d cycles", exec_len);
            n_len++;
        end

    kfin_after_exec: assert property (@(posedge clk) disable iff (rst)
        $fell(exec) |-> k_fin)
        else begin
            $error("k_fin missing after exec fell");
            n_kfin++;
        end

    // job end is a single-cycle pulse
    sfin_pulse: assert property (@(posedge clk) disable iff (rst)
        s_fin |=> !s_fin)
        else begin
            $error("s_fin held for more than one cycle");
            n_sfin++;
        end

endmodule

// File: testbench/mv_engine_tb.sv
`timescale 1ns/1ps

module mv_engine_tb
    import accel_geom_pkg::*;
    import accel_data_pkg::*;
();

    localparam int BEAT_TIMEOUT = 4000;
    localparam int FIN_TIMEOUT  = 500;

    logic         clk;
    logic         rst;
    load_req_t    load;
    logic         s_init;
    logic         res_credit;
    logic         s_fin;
    logic         res_valid;
    result_beat_t res_beat;

    // host copy of both operand stores
    operand_t src_ref [ROWS*COLS];
    operand_t mat_ref [COLS];
    acc_t     exp_sum [ROWS];

    // owned by the monitor
    row_idx_t exp_row;
    int       beat_cnt;
    int       fin_cnt;
    int       mon_errors = 0;
    // owned by the main sequence
    int       errors = 0;
    int       err_mark = 0;
    int       held = 0;
    int       tests_run = 0;
    int       tests_failed = 0;

    mv_engine_top uut (
        .clk(clk), .rst(rst), .load(load), .s_init(s_init),
        .res_credit(res_credit), .s_fin(s_fin),
        .res_valid(res_valid), .res_beat(res_beat)
    );

    // sender side gets dummy framing, sequencer side dummy credits
    bind exe_ctrl mv_engine_props chk (
        .clk(clk), .rst(rst), .exec(exec), .k_fin(k_fin), .s_fin(s_fin),
        .res_valid(1'b0), .res_credit(1'b0), .credits('0)
    );
    bind result_sender mv_engine_props chk (
        .clk(clk), .rst(rst), .exec(1'b0), .k_fin(1'b0), .s_fin(1'b0),
        .res_valid(res_valid), .res_credit(res_credit), .credits(credits)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stream monitor
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            exp_row  <= '0;
            beat_cnt <= 0;
            fin_cnt  <= 0;
        end else begin
            if (res_valid) begin
                // rows leave in order 0..7
                assert (res_beat.row == exp_row) else begin
                    $display("CHECK FAILED: res_beat.row = %h, expected %h",
                             res_beat.row, exp_row);
                    mon_errors++;
                end
                assert (res_beat.value == exp_sum[exp_row]) else begin
                    $display("CHECK FAILED: res_beat.value = %h, expected %h",
                             res_beat.value, exp_sum[exp_row]);
                    mon_errors++;
                end
                exp_row  <= exp_row + 1'b1;
                beat_cnt <= beat_cnt + 1;
            end
            if (s_fin) begin
                // only after the last row of a job
                assert (beat_cnt != 0 && beat_cnt % ROWS == 0) else begin
                    $display("s_fin pulsed after %0d beats, not at a job end", beat_cnt);
                    mon_errors++;
                end
                fin_cnt <= fin_cnt + 1;
            end
        end
    end

    function automatic int total_errors();
        return errors + mon_errors + uut.u_ctrl.chk.fail_cnt + uut.u_send.chk.fail_cnt;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // host and consumer tasks
    //////////////////////////////////////////////////////////////////////
    task automatic load_word(input logic to_mat, input src_addr_t addr, input operand_t data);
        load_req_t req;
        req.valid     = 1'b1;
        req.to_matrix = to_mat;
        req.addr      = addr;
        req.data      = data;
        @(posedge clk);
        load <= req;
    endtask

    task automatic load_source();
        for (int a = 0; a < ROWS*COLS; a++) begin
            src_ref[a] = operand_t'($urandom);
            load_word(1'b0, src_addr_t'(a), src_ref[a]);
        end
        @(posedge clk);
        load <= '0;
    endtask

    task automatic load_matrix();
        for (int a = 0; a < COLS; a++) begin
            mat_ref[a] = operand_t'($urandom);
            load_word(1'b1, src_addr_t'(a), mat_ref[a]);
        end
        @(posedge clk);
        load <= '0;
    endtask

    // row i sums src[i*128+j] * mat[j]
    task automatic compute_expected();
        acc_t sum;
        for (int i = 0; i < ROWS; i++) begin
            sum = '0;
            for (int j = 0; j < COLS; j++) begin
                sum += acc_t'(src_ref[i*COLS + j]) * acc_t'(mat_ref[j]);
            end
            exp_sum[i] = sum;
        end
    endtask

    task automatic start_job();
        @(posedge clk);
        s_init <= 1'b1;
        @(posedge clk);
        s_init <= 1'b0;
    endtask

    // consumer keeps back one credit per beat until give is set
    task automatic collect_beats(input int target, input bit give);
        int n;
        n = 0;
        while ((beat_cnt < target || (give && held != 0)) && n < BEAT_TIMEOUT) begin
            @(posedge clk);
            if (res_valid) begin
                held++;
            end
            if (give && held != 0) begin
                res_credit <= 1'b1;
                held--;
            end else begin
                res_credit <= 1'b0;
            end
            n++;
        end
        @(posedge clk);
        res_credit <= 1'b0;
        if (n >= BEAT_TIMEOUT) begin
            $display("timeout waiting for result beat %0d, got %0d", target, beat_cnt);
            errors++;
        end
    endtask

    task automatic wait_job_end(input int target);
        int n;
        n = 0;
        while (fin_cnt < target && n < FIN_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= FIN_TIMEOUT) begin
            $display("timeout waiting for s_fin of job %0d", target);
            errors++;
        end
    endtask

    // settle, then nothing extra may have arrived
    task automatic check_counts(input int beats, input int fins);
        repeat (20) @(posedge clk);
        assert (beat_cnt == beats) else begin
            $display("CHECK FAILED: beat count = %h, expected %h", beat_cnt, beats);
            errors++;
        end
        assert (fin_cnt == fins) else begin
            $display("CHECK FAILED: s_fin count = %h, expected %h", fin_cnt, fins);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int now_err;
        now_err = total_errors();
        tests_run++;
        if (now_err != err_mark) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
        err_mark = now_err;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h29d27c92));
        rst        = 1'b1;
        load       = '0;
        s_init     = 1'b0;
        res_credit = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // quiet outputs with no job
        check_counts(0, 0);
        repeat (50) @(posedge clk);
        check_counts(0, 0);
        finish_test("idle after reset");

        load_source();
        load_matrix();
        compute_expected();
        start_job();
        collect_beats(8, 1'b1);
        wait_job_end(1);
        check_counts(8, 1);
        finish_test("job with prompt credits");

        // four credits drain, then the stream stalls
        start_job();
        collect_beats(12, 1'b0);
        repeat (400) @(posedge clk);
        check_counts(12, 1);
        collect_beats(16, 1'b1);
        wait_job_end(2);
        check_counts(16, 2);
        finish_test("job under back-pressure");

        // new matrix against the old source rows
        load_matrix();
        compute_expected();
        start_job();
        collect_beats(24, 1'b1);
        wait_job_end(3);
        check_counts(24, 3);
        finish_test("matrix reload");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mv_engine_top.f
logic/accel_geom_pkg.sv
logic/accel_data_pkg.sv
logic/agu_next.sv
logic/exe_ctrl.sv
logic/operand_store.sv
logic/mac_unit.sv
logic/result_sender.sv
logic/mv_engine_top.sv
testbench/mv_engine_props.sv
testbench/mv_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mv_engine_tb
FILELIST  ?= mv_engine_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
